//--- wb_stage.f
+incdir+src
src/wb_pkg.sv
src/wb_pc_tracker.sv
src/wb_load_unit.sv
src/wb_commit_ctrl.sv
src/wb_stage.sv
tests/tb_wb_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build the writeback stage testbench with Verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_wb_stage \
    -f wb_stage.f -o sim_wb_stage

./obj_dir/sim_wb_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1

//--- tests/tb_wb_stage.sv
// Random-stimulus testbench for the writeback stage with a cycle-level model
// Built from the project file list with tb_wb_stage as the top module

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module tb_wb_stage;

    import wb_pkg::*;

    localparam logic [31:0] SEED       = 32'h0a23_0685;
    localparam int          NUM_INSTR  = 400;
    localparam int          WAIT_LIMIT = 16;    // Longest legal stall is 8 cycles

    // Instruction kinds
    localparam int K_ARITH = 0;
    localparam int K_LOAD  = 1;
    localparam int K_STORE = 2;
    localparam int K_NT    = 3;
    localparam int K_TAKEN = 4;
    localparam int K_JAL   = 5;
    localparam int K_JALR  = 6;

    logic               g_clk;
    logic               g_resetn;
    logic               s4_valid;
    logic               s4_busy;
    logic [4:0]         s4_rd;
    xword_t             s4_opr_a;
    xword_t             s4_opr_b;
    wb_uop_u            s4_uop;
    logic [`WB_FU_W-1:0] s4_fu;
    logic [1:0]         s4_size;
    logic               cf_req;
    xword_t             cf_target;
    logic               cf_ack;
    logic               dmem_recv;
    logic               dmem_ack;
    xword_t             dmem_rdata;
    logic               gpr_wen;
    logic [4:0]         gpr_rd;
    xword_t             gpr_wdata;

    logic [31:0] lfsr_state;
    xword_t      model_pc;     // Model copy of the stage PC
    xword_t      cur_a;
    xword_t      mem_data;     // Data of the real response
    logic [1:0]  cur_size;
    logic [4:0]  cur_rd;
    bit          wants_cf;     // Op raises cf_req
    bit          wants_mem;    // Op waits on a memory response
    int          cf_dly;
    int          rsp_dly;

    wb_stage DUT (.*);

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    // ------------------------------------------------------------------------
    // Random numbers and reference functions
    // ------------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    // Pick byte or half by offset, then extend
    function automatic xword_t load_model(input xword_t word, input logic [1:0] addr,
                                          input logic [1:0] sz, input logic sgn);
        xword_t sh;
        sh = word >> (8 * addr);
        case (sz)
            2'b00:   return sgn ? {{(`WB_XLEN-8){sh[7]}}, sh[7:0]}
                                : {{(`WB_XLEN-8){1'b0}}, sh[7:0]};
            2'b01:   return sgn ? {{(`WB_XLEN-16){sh[15]}}, sh[15:0]}
                                : {{(`WB_XLEN-16){1'b0}}, sh[15:0]};
            default: return word;
        endcase
    endfunction

    function automatic int pick_kind();
        logic [2:0] sel;
        sel = 3'(rand_bits(3));
        case (sel)
            3'd0, 3'd1: return K_ARITH;
            3'd2, 3'd3: return K_LOAD;
            3'd4:       return K_STORE;
            3'd5:       return K_NT;
            3'd6:       return K_TAKEN;
            default:    return (1'(rand_bits(1)) == 1'b1) ? K_JALR : K_JAL;
        endcase
    endfunction

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, name, got, exp));
    endtask

    task automatic check_gpr(input logic [4:0] exp_rd, input xword_t exp_data);
        if (gpr_wen !== 1'b1 || gpr_rd !== exp_rd || gpr_wdata !== exp_data)
            fail_run($sformatf("mismatch at %0t: gpr wen=%b rd=%0d data=%h, exp rd=%0d data=%h",
                               $time, gpr_wen, gpr_rd, gpr_wdata, exp_rd, exp_data));
    endtask

    task automatic check_cf(input xword_t exp_target);
        if (cf_req !== 1'b1 || cf_target !== exp_target)
            fail_run($sformatf("mismatch at %0t: cf_req=%b target=%h, expected target %h",
                               $time, cf_req, cf_target, exp_target));
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    // Ack and response lines for cycle cyc of the held op
    task automatic drive_env(input int cyc);
        cf_ack <= wants_cf && (cyc == cf_dly);
        if (wants_mem && cyc < rsp_dly) begin
            dmem_recv  <= 1'b0;
            dmem_rdata <= rand_bits(32);
        end else if (wants_mem && cyc == rsp_dly) begin
            dmem_recv  <= 1'b1;             // The real response
            dmem_rdata <= mem_data;
        end else begin
            dmem_recv  <= 1'(rand_bits(1)); // Junk while ack is low
            dmem_rdata <= rand_bits(32);
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge g_clk);
            s4_valid   <= 1'b0;
            cf_ack     <= 1'b0;
            dmem_recv  <= 1'(rand_bits(1));
            dmem_rdata <= rand_bits(32);
            @(negedge g_clk);
            check_flag("cf_req", cf_req, 1'b0);
            check_flag("dmem_ack", dmem_ack, 1'b0);
            check_flag("gpr_wen", gpr_wen, 1'b0);
        end
    endtask

    task automatic run_instr(input int kind);
        int         cyc;
        int         retire_cyc;
        bit         done;
        bit         has_write;
        xword_t     exp_data;
        xword_t     cur_b;
        wb_uop_u    uop;
        lsu_uop_t   lop;
        logic [1:0] acc_sz;
        logic [`WB_FU_W-1:0] fu;
        cur_rd    = 5'(rand_bits(5));
        cur_a     = rand_bits(32);
        cur_b     = rand_bits(32);
        cur_size  = 2'(rand_bits(2));
        uop       = 5'(rand_bits(5));
        cf_dly    = int'(rand_bits(3));
        rsp_dly   = int'(rand_bits(3));
        mem_data  = rand_bits(32);
        acc_sz    = 2'(rand_bits(2));
        if (acc_sz == 2'b11)
            acc_sz = LSU_WORD;
        lop.load  = (kind == K_LOAD);
        lop.store = (kind == K_STORE);
        lop.size  = lsu_size_e'(acc_sz);
        lop.sign  = 1'(rand_bits(1));
        if (acc_sz == LSU_HALF)
            cur_b[0] = 1'b0;                // Aligned halves and words only
        if (acc_sz == LSU_WORD)
            cur_b[1:0] = 2'b00;
        fu         = '0;
        wants_cf   = 1'b0;
        wants_mem  = 1'b0;
        has_write  = 1'b0;
        exp_data   = '0;
        retire_cyc = 0;
        case (kind)
            K_ARITH: begin
                fu[`WB_FU_ARITH] = 1'b1;
                has_write = 1'b1;
                exp_data  = cur_a;
            end
            K_LOAD, K_STORE: begin
                fu[`WB_FU_LSU] = 1'b1;
                uop.lsu    = lop;
                wants_mem  = 1'b1;
                retire_cyc = rsp_dly + 1;   // Data registered first
                has_write  = (kind == K_LOAD);
                exp_data   = load_model(mem_data, cur_b[1:0], acc_sz, lop.sign);
            end
            K_NT: begin
                fu[`WB_FU_CFU] = 1'b1;
                uop.cfu = CFU_NOT_TAKEN;
            end
            default: begin
                fu[`WB_FU_CFU] = 1'b1;
                uop.cfu    = (kind == K_TAKEN) ? CFU_TAKEN :
                             (kind == K_JAL)   ? CFU_JAL : CFU_JALR;
                wants_cf   = 1'b1;
                retire_cyc = cf_dly;
                has_write  = (kind != K_TAKEN);
                exp_data   = model_pc + 32'(cur_size) * 32'd2;  // Link value
            end
        endcase

        @(posedge g_clk);
        s4_valid <= 1'b1;
        s4_rd    <= cur_rd;
        s4_opr_a <= cur_a;
        s4_opr_b <= cur_b;
        s4_uop   <= uop;
        s4_fu    <= fu;
        s4_size  <= cur_size;
        drive_env(0);
        cyc  = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge g_clk);
            check_flag("s4_busy", s4_busy, cyc != retire_cyc);
            check_flag("dmem_ack", dmem_ack, wants_mem && cyc <= rsp_dly);
            if (wants_cf)
                check_cf(cur_a);            // Target held until ack
            else
                check_flag("cf_req", cf_req, 1'b0);
            if (has_write && cyc == retire_cyc)
                check_gpr(cur_rd, exp_data);
            else
                check_flag("gpr_wen", gpr_wen, 1'b0);
            if (!s4_busy) begin
                done = 1'b1;
            end else if (cyc >= WAIT_LIMIT) begin
                fail_run($sformatf("timeout: stage still busy after %0d cycles", cyc));
            end else begin
                @(posedge g_clk);
                cyc++;
                drive_env(cyc);
            end
        end
        model_pc = wants_cf ? cur_a : model_pc + 32'(cur_size) * 32'd2;
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        g_resetn   = 1'b0;
        s4_valid   = 1'b0;
        s4_rd      = '0;
        s4_opr_a   = '0;
        s4_opr_b   = '0;
        s4_uop     = '0;
        s4_fu      = '0;
        s4_size    = '0;
        cf_ack     = 1'b0;
        dmem_recv  = 1'b0;
        dmem_rdata = '0;
        lfsr_state = SEED;
        model_pc   = `WB_PC_RESET;
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;
        idle_cycles(2);
        run_instr(K_JAL);                   // Links from the reset PC
        for (int n = 0; n < NUM_INSTR; n++) begin
            run_instr(pick_kind());
            if (2'(rand_bits(2)) == 2'b00)
                idle_cycles(1 + int'(rand_bits(2)));
        end
        idle_cycles(1);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/wb_stage.sv
// Writeback stage top level of the pipeline
// Joins the PC tracker, load unit and commit control

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_stage (
    input  logic                 g_clk,       // Clock
    input  logic                 g_resetn,    // Sync reset, active low
    input  logic                 s4_valid,    // Instruction present
    output logic                 s4_busy,     // Stage stalled
    input  logic [4:0]           s4_rd,       // Destination register
    input  wb_pkg::xword_t       s4_opr_a,    // Result or target
    input  wb_pkg::xword_t       s4_opr_b,    // Memory address
    input  wb_pkg::wb_uop_u      s4_uop,      // Micro-op
    input  logic [`WB_FU_W-1:0]  s4_fu,       // Unit select
    input  logic [1:0]           s4_size,     // Length in halfwords
    output logic                 cf_req,      // Control-flow request
    output wb_pkg::xword_t       cf_target,   // Control-flow target
    input  logic                 cf_ack,      // Control-flow ack
    input  logic                 dmem_recv,   // Memory response valid
    output logic                 dmem_ack,    // Memory response taken
    input  wb_pkg::xword_t       dmem_rdata,  // Memory response data
    output logic                 gpr_wen,     // Register write
    output logic [4:0]           gpr_rd,      // Register index
    output wb_pkg::xword_t       gpr_wdata    // Register data
);

    import wb_pkg::*;

    logic   lsu_busy;
    logic   lsu_wen;
    xword_t lsu_wdata;
    logic   cf_busy;
    logic   link_wen;
    xword_t link_wdata;

    wb_pc_tracker u_pc_tracker (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s4_valid   (s4_valid),
        .s4_busy    (s4_busy),
        .s4_fu      (s4_fu),
        .s4_uop     (s4_uop),
        .s4_size    (s4_size),
        .s4_opr_a   (s4_opr_a),
        .cf_ack     (cf_ack),
        .cf_req     (cf_req),
        .cf_target  (cf_target),
        .cf_busy    (cf_busy),
        .link_wen   (link_wen),
        .link_wdata (link_wdata)
    );

    wb_load_unit u_load_unit (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s4_valid   (s4_valid),
        .s4_fu      (s4_fu),
        .s4_uop     (s4_uop),
        .s4_opr_b   (s4_opr_b),
        .dmem_recv  (dmem_recv),
        .dmem_rdata (dmem_rdata),
        .dmem_ack   (dmem_ack),
        .lsu_busy   (lsu_busy),
        .lsu_wen    (lsu_wen),
        .lsu_wdata  (lsu_wdata)
    );

    wb_commit_ctrl u_commit_ctrl (
        .s4_valid   (s4_valid),
        .s4_fu      (s4_fu),
        .s4_rd      (s4_rd),
        .s4_opr_a   (s4_opr_a),
        .lsu_busy   (lsu_busy),
        .lsu_wen    (lsu_wen),
        .lsu_wdata  (lsu_wdata),
        .cf_busy    (cf_busy),
        .link_wen   (link_wen),
        .link_wdata (link_wdata),
        .s4_busy    (s4_busy),
        .gpr_wen    (gpr_wen),
        .gpr_rd     (gpr_rd),
        .gpr_wdata  (gpr_wdata)
    );

endmodule

`default_nettype wire

//--- src/wb_commit_ctrl.sv
// Commit control for the writeback stage
// Forms stage busy and picks the register write source at retire

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_commit_ctrl (
    input  logic                 s4_valid,    // Stage holds an instruction
    input  logic [`WB_FU_W-1:0]  s4_fu,       // One-hot unit select
    input  logic [4:0]           s4_rd,       // Destination register
    input  wb_pkg::xword_t       s4_opr_a,    // Arithmetic result
    input  logic                 lsu_busy,    // Memory response pending
    input  logic                 lsu_wen,     // Load data held
    input  wb_pkg::xword_t       lsu_wdata,   // Load data
    input  logic                 cf_busy,     // Control-flow ack pending
    input  logic                 link_wen,    // Jump link ready
    input  wb_pkg::xword_t       link_wdata,  // Return address
    output logic                 s4_busy,     // Stall upstream
    output logic                 gpr_wen,     // Register write enable
    output logic [4:0]           gpr_rd,      // Register index
    output wb_pkg::xword_t       gpr_wdata    // Register data
);

    import wb_pkg::*;

    logic   arith_wen;    // Arithmetic class writes opr_a
    logic   retire;
    xword_t arith_term;
    xword_t lsu_term;
    xword_t link_term;

    // ------------------------------------------------------------------------
    // Stall and retire
    // ------------------------------------------------------------------------

    assign s4_busy = lsu_busy || cf_busy;    // Either unit can hold us
    assign retire  = s4_valid && !s4_busy;

    // ------------------------------------------------------------------------
    // Write source select
    // ------------------------------------------------------------------------

    // ALU, MUL, ASI and BIT all land here
    assign arith_wen = s4_valid && s4_fu[`WB_FU_ARITH];

    // Sources are exclusive, so AND-OR is enough
    assign arith_term = {`WB_XLEN{arith_wen}} & s4_opr_a;
    assign lsu_term   = {`WB_XLEN{lsu_wen}}   & lsu_wdata;
    assign link_term  = {`WB_XLEN{link_wen}}  & link_wdata;

    assign gpr_wdata = arith_term | lsu_term | link_term;
    assign gpr_rd    = s4_rd;

    // Write only on the retire cycle
    assign gpr_wen = retire && (arith_wen || lsu_wen || link_wen);

    // Enables come from three units and must never overlap
    always_comb begin
        a_one_source: assert final ($onehot0({arith_wen, lsu_wen, link_wen}))
            else $error("more than one writeback source active");
    end

endmodule

`default_nettype wire

//--- src/wb_load_unit.sv
// Data memory response handling for loads and stores in the writeback stage
// Aligns and extends load data, then holds it one cycle for the register write

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_load_unit (
    input  logic                 g_clk,       // Clock
    input  logic                 g_resetn,    // Sync reset, active low
    input  logic                 s4_valid,    // Stage holds an instruction
    input  logic [`WB_FU_W-1:0]  s4_fu,       // One-hot unit select
    input  wb_pkg::wb_uop_u      s4_uop,      // Micro-op
    input  wb_pkg::xword_t       s4_opr_b,    // Access address
    input  logic                 dmem_recv,   // Response present
    input  wb_pkg::xword_t       dmem_rdata,  // Response data
    output logic                 dmem_ack,    // Response accepted
    output logic                 lsu_busy,    // Waiting on a response
    output logic                 lsu_wen,     // Load result ready
    output wb_pkg::xword_t       lsu_wdata    // Aligned load result
);

    import wb_pkg::*;

    lsu_uop_t    lsu_op;      // Memory view of the uop
    logic        mem_op;
    logic        rsp_take;
    logic        rsp_held;    // One-entry register is full
    xword_t      rsp_data;    // Registered result
    logic [1:0]  addr_lo;     // Byte offset in word
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    xword_t      aligned;

    assign lsu_op = s4_uop.lsu;
    assign mem_op = s4_valid && s4_fu[`WB_FU_LSU] && (lsu_op.load || lsu_op.store);

    // ------------------------------------------------------------------------
    // Response handshake
    // ------------------------------------------------------------------------

    // One response per op, then stop accepting
    assign lsu_busy = mem_op && !rsp_held;
    assign dmem_ack = lsu_busy;
    assign rsp_take = dmem_recv && dmem_ack;   // Unacked responses dropped

    // ------------------------------------------------------------------------
    // Alignment and extension
    // ------------------------------------------------------------------------

    assign addr_lo  = s4_opr_b[1:0];
    assign sel_byte = dmem_rdata[{addr_lo, 3'b000} +: 8];       // Addressed byte
    assign sel_half = dmem_rdata[{addr_lo[1], 4'b0000} +: 16];  // Upper or lower half

    always_comb begin
        case (lsu_op.size)
            LSU_BYTE: aligned = {{(`WB_XLEN-8){lsu_op.sign && sel_byte[7]}}, sel_byte};
            LSU_HALF: aligned = {{(`WB_XLEN-16){lsu_op.sign && sel_half[15]}}, sel_half};
            default:  aligned = dmem_rdata;     // Whole word
        endcase
    end

    // ------------------------------------------------------------------------
    // Response register
    // ------------------------------------------------------------------------

    // Op retires while held, so the flag lasts one cycle
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            rsp_held <= 1'b0;
        end else begin
            rsp_held <= rsp_take;
        end
    end

    always_ff @(posedge g_clk) begin
        if (rsp_take) begin
            rsp_data <= aligned;
        end
    end

    // Stores complete without a write
    assign lsu_wen   = rsp_held && mem_op && lsu_op.load;
    assign lsu_wdata = rsp_data;

    // Upstream keeps the memory op in place until it retires
    a_held_is_mem: assert property (@(posedge g_clk) disable iff (!g_resetn)
        rsp_held |-> mem_op);

endmodule

`default_nettype wire

//--- src/wb_pc_tracker.sv
// Stage program counter, control-flow requests and jump link values
// Instantiated by the writeback stage top level

`timescale 1ns/10ps
`default_nettype none

`include "wb_defs.svh"

module wb_pc_tracker (
    input  logic                 g_clk,      // Clock
    input  logic                 g_resetn,   // Sync reset, active low
    input  logic                 s4_valid,   // Stage holds an instruction
    input  logic                 s4_busy,    // Stage stalled
    input  logic [`WB_FU_W-1:0]  s4_fu,      // One-hot unit select
    input  wb_pkg::wb_uop_u      s4_uop,     // Micro-op
    input  logic [1:0]           s4_size,    // Length in halfwords
    input  wb_pkg::xword_t       s4_opr_a,   // Jump / branch target
    input  logic                 cf_ack,     // Change accepted
    output logic                 cf_req,     // Control-flow change request
    output wb_pkg::xword_t       cf_target,  // Where to go
    output logic                 cf_busy,    // Waiting on cf_ack
    output logic                 link_wen,   // Link write this cycle
    output wb_pkg::xword_t       link_wdata  // Return address
);

    import wb_pkg::*;

    xword_t  s4_pc;     // PC of the held instruction
    xword_t  n_s4_pc;   // Next sequential PC
    cfu_op_e cfu_op;    // Control-flow view of the uop
    logic    fu_cfu;
    logic    cf_taken;
    logic    cf_link;
    logic    cf_done;
    logic    retire;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    assign fu_cfu = s4_valid && s4_fu[`WB_FU_CFU];
    assign cfu_op = s4_uop.cfu;

    // Anything but a not-taken branch redirects
    assign cf_taken = fu_cfu && (cfu_op == CFU_TAKEN ||
                                 cfu_op == CFU_JAL   ||
                                 cfu_op == CFU_JALR);

    assign cf_link  = fu_cfu && (cfu_op == CFU_JAL || cfu_op == CFU_JALR);

    // ------------------------------------------------------------------------
    // Request handshake
    // ------------------------------------------------------------------------

    assign cf_req    = cf_taken;            // Held until acked
    assign cf_target = s4_opr_a;            // Computed upstream
    assign cf_done   = cf_req && cf_ack;    // Change completes here
    assign cf_busy   = cf_req && !cf_ack;   // Stall until then

    // Link written in the ack cycle only
    assign link_wen   = cf_link && cf_ack;
    assign link_wdata = n_s4_pc;

    // ------------------------------------------------------------------------
    // Stage PC
    // ------------------------------------------------------------------------

    assign n_s4_pc = s4_pc + {{(`WB_XLEN-3){1'b0}}, s4_size, 1'b0}; // 2 bytes per unit
    assign retire  = s4_valid && !s4_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            s4_pc <= `WB_PC_RESET;
        end else if (cf_done) begin
            s4_pc <= cf_target;     // Redirect wins
        end else if (retire) begin
            s4_pc <= n_s4_pc;       // Fall through
        end
    end

    // Upstream must hold the target while the request waits
    a_target_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        cf_busy |=> cf_req && $stable(cf_target));

endmodule

`default_nettype wire

//--- src/wb_pkg.sv
// Shared types for the writeback stage, the data word and micro-op views
// Compile ahead of the stage modules

`default_nettype none

`include "wb_defs.svh"

package wb_pkg;

    // Data / address word
    typedef logic [`WB_XLEN-1:0] xword_t;

    // Memory access size
    typedef enum logic [1:0] {
        LSU_BYTE = 2'b00,
        LSU_HALF = 2'b01,
        LSU_WORD = 2'b10
    } lsu_size_e;

    // Memory view of a micro-op, 5 bits
    typedef struct packed {
        logic      load;  // Load op
        logic      store; // Store op
        lsu_size_e size;  // Access size
        logic      sign;  // Sign-extend load data
    } lsu_uop_t;

    // Control-flow view of a micro-op
    typedef enum logic [`WB_UOP_W-1:0] {
        CFU_NOT_TAKEN = 'd0, // Branch, falls through
        CFU_TAKEN     = 'd1, // Branch, taken
        CFU_JAL       = 'd2, // Direct jump and link
        CFU_JALR      = 'd3  // Indirect jump and link
    } cfu_op_e;

    // Same micro-op bits, decoded per unit
    typedef union packed {
        lsu_uop_t lsu; // Load unit view
        cfu_op_e  cfu; // PC tracker view
    } wb_uop_u;

endpackage

`default_nettype wire

//--- src/wb_defs.svh
// Widths, functional-unit select positions and reset PC for the writeback stage
// Include in any file that sizes ports or decodes the unit select

`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Data and address width
`define WB_XLEN 32

// Micro-op width, shared by both union views
`define WB_UOP_W 5

// One-hot functional-unit select
`define WB_FU_W 3

// Bit positions in the unit select
`define WB_FU_ARITH 0 // ALU, MUL, ASI and BIT merged
`define WB_FU_LSU   1 // Loads and stores
`define WB_FU_CFU   2 // Branches and jumps

// Stage PC after reset
`define WB_PC_RESET 32'h8000_0000

`endif
